// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_etx
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: etx_arbiter.sv
`timescale 1ns/100ps

module etx_arbiter (
   input  logic                tx_lclk_par,
   input  logic                rst,
   input  logic                wr_valid,         // Write queue not empty
   input  etx_pkg::emesh_txn_t wr_head,
   input  logic                rq_valid,         // Read request queue not empty
   input  etx_pkg::emesh_txn_t rq_head,
   input  logic                rr_valid,         // Read response queue not empty
   input  etx_pkg::emesh_txn_t rr_head,
   input  logic                proto_ready,      // Engine can take a strobe next cycle
   input  logic                etx_rd_wait,      // Synced read pushback
   input  logic                etx_wr_wait,      // Synced write pushback
   output logic                wr_pop,
   output logic                rq_pop,
   output logic                rr_pop,
   output logic                etx_access,       // Single-cycle strobe to engine
   output etx_pkg::emesh_txn_t etx_txn
);
   import etx_pkg::*;

   logic       rr_ok;                            // Eligible after wait masking
   logic       rq_ok;
   logic       wr_ok;
   logic       slot_free;                        // Ready and nothing already in flight
   logic       grant;
   chan_e      sel;                              // Winning channel this cycle
   emesh_txn_t sel_txn;

   // Read responses and writes both ride the write path
   assign rr_ok = rr_valid && !etx_wr_wait;
   assign rq_ok = rq_valid && !etx_rd_wait;
   assign wr_ok = wr_valid && !etx_wr_wait;

   // A strobe already registered will be taken this cycle, so hold off
   assign slot_free = proto_ready && !etx_access;

   // Fixed priority, responses first
   always_comb
   begin
      grant = 1'b0;
      sel   = CH_WR;
      if (slot_free)
      begin
         if (rr_ok)
         begin
            grant = 1'b1;
            sel   = CH_RR;
         end
         else if (rq_ok)
         begin
            grant = 1'b1;
            sel   = CH_RQ;
         end
         else if (wr_ok)
         begin
            grant = 1'b1;
            sel   = CH_WR;
         end
      end
   end

   always_comb
   begin
      case (sel)
         CH_RR:   sel_txn = rr_head;
         CH_RQ:   sel_txn = rq_head;
         default: sel_txn = wr_head;
      endcase
   end

   // One pop at most, same cycle as the grant
   assign rr_pop = grant && (sel == CH_RR);
   assign rq_pop = grant && (sel == CH_RQ);
   assign wr_pop = grant && (sel == CH_WR);

   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         etx_access <= 1'b0;
      end
      else
      begin
         etx_access <= grant;                    // Strobe one cycle after the pop
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (grant)
      begin
         etx_txn <= sel_txn;                     // Captured head of the popped queue
      end
   end

endmodule

// File: etx_assertions.sv
`timescale 1ns/100ps

module etx_assertions (
   input logic                        tx_lclk_par,
   input logic                        rst,
   input logic [etx_pkg::FRAME_W-1:0] tx_frame_par,
   input logic                        wr_pop,
   input logic                        rq_pop,
   input logic                        rr_pop,
   input logic                        etx_access,
   input logic                        proto_ready
);
   import etx_pkg::*;

   // Frame is all lanes or none
   frame_legal: assert property (@(posedge tx_lclk_par) disable iff (rst)
      (tx_frame_par == FRAME_ON) || (tx_frame_par == '0))
      else $error("Frame bus holds a partial value");

   one_pop: assert property (@(posedge tx_lclk_par) disable iff (rst)
      $onehot0({wr_pop, rq_pop, rr_pop}))
      else $error("More than one queue popped in a cycle");

   // Strobe follows a grant taken while the engine was free and is taken at once
   access_ready: assert property (@(posedge tx_lclk_par) disable iff (rst)
      etx_access |-> $past(proto_ready) && proto_ready)
      else $error("Access strobe without engine ready");

   no_frame_in_reset: assert property (@(posedge tx_lclk_par)
      rst && $past(rst) |-> (tx_frame_par == '0))
      else $error("Frame driven during reset");

endmodule

bind etx_top etx_assertions link_checks (.tx_lclk_par(tx_lclk_par), .rst(rst),
   .tx_frame_par(tx_frame_par), .wr_pop(wr_pop), .rq_pop(rq_pop), .rr_pop(rr_pop),
   .etx_access(etx_access), .proto_ready(proto_ready));

// File: etx_channel_fifo.sv
`timescale 1ns/100ps

module etx_channel_fifo (
   input  logic                tx_lclk_par,
   input  logic                rst,
   input  logic                wr_strobe,        // One entry per high cycle
   input  etx_pkg::emesh_txn_t wr_txn,
   input  logic                pop,              // Drops the head at this edge
   output logic                head_valid,
   output etx_pkg::emesh_txn_t head_txn,
   output logic                progfull          // Advisory level for the writer
);
   import etx_pkg::*;

   emesh_txn_t         mem [FIFO_DEPTH];         // Circular entry storage
   logic [FIFO_AW-1:0] wr_ptr;                   // Next slot to fill
   logic [FIFO_AW-1:0] rd_ptr;                   // Current head slot
   logic [FIFO_AW:0]   count;                    // 0 to FIFO_DEPTH entries
   logic               full;
   logic               do_wr;                    // Write that actually lands
   logic               do_rd;                    // Pop that actually removes

   assign full       = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign head_valid = (count != '0);            // Entry visible the cycle after its write
   assign do_wr      = wr_strobe && !full;       // Overflowing write is dropped
   assign do_rd      = pop && head_valid;        // Pop on empty is ignored
   assign head_txn   = mem[rd_ptr];              // Show-ahead head

   // Entry storage
   always_ff @(posedge tx_lclk_par)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wr_txn;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         progfull <= 1'b0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;             // Wraps at the power-of-two depth
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;      // Fill only
            2'b01:   count <= count - 1'b1;      // Drain only
            default: count <= count;             // Both or neither
         endcase
         // Follows the registered count one cycle later
         progfull <= (count >= (FIFO_AW+1)'(PROGFULL_LEVEL));
      end
   end

endmodule

// File: etx_pkg.sv
package etx_pkg;

   // Queue sizing
   localparam int FIFO_DEPTH     = 8;            // Entries per channel queue
   localparam int FIFO_AW        = 3;            // Read and write pointer width
   localparam int PROGFULL_LEVEL = 6;            // Fill count that raises progfull

   // Parallel link widths
   localparam int PAR_DW  = 64;                  // Two 32-bit halves per beat
   localparam int FRAME_W = 8;                   // One frame bit per byte lane

   // Packet constants
   localparam logic [FRAME_W-1:0] FRAME_ON = {FRAME_W{1'b1}}; // Frame while a beat is valid
   localparam logic HDR_ACCESS_BIT = 1'b1;       // Lowest bit of the header byte

   // One emesh transaction, 103 bits, write flag in the MSB
   typedef struct packed {
      logic        write;                        // Write or read response
      logic [1:0]  datamode;                     // Access size
      logic [3:0]  ctrlmode;                     // Control bits, passed through
      logic [31:0] dstaddr;                      // Target address
      logic [31:0] data;                         // Write data or read return
      logic [31:0] srcaddr;                      // Return address for reads
   } emesh_txn_t;

   // Channel identity used in arbitration
   typedef enum logic [1:0] {
      CH_WR,                                     // Write requests
      CH_RQ,                                     // Read requests
      CH_RR                                      // Read responses
   } chan_e;

   // Packet engine states, named by the beat on the bus
   typedef enum logic [1:0] {
      ST_IDLE,                                   // Bus quiet, frame low
      ST_HEADER,                                 // Header beat driven
      ST_PAYLOAD                                 // Payload beat driven
   } proto_state_e;

endpackage

// File: etx_protocol.sv
`timescale 1ns/100ps

module etx_protocol (
   input  logic                          tx_lclk_par,
   input  logic                          rst,
   input  logic                          etx_access,   // Strobe from arbiter
   input  etx_pkg::emesh_txn_t           etx_txn,
   input  logic                          tx_rd_wait,   // Raw pushback from the link
   input  logic                          tx_wr_wait,
   output logic                          proto_ready,
   output logic                          etx_rd_wait,
   output logic                          etx_wr_wait,
   output logic [etx_pkg::FRAME_W-1:0]   tx_frame_par,
   output logic [etx_pkg::PAR_DW-1:0]    tx_data_par
);
   import etx_pkg::*;

   proto_state_e      state;                     // Beat currently on the bus
   emesh_txn_t        txn_q;                     // Held for the payload beat
   logic [1:0]        wait_meta;                 // First sync stage {wr, rd}
   logic [1:0]        wait_sync;                 // Second sync stage
   logic              accept;
   logic [7:0]        hdr_byte;
   logic [PAR_DW-1:0] hdr_beat;
   logic [PAR_DW-1:0] pay_beat;

   // Two-flop pushback synchronizer
   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         wait_meta <= '0;
         wait_sync <= '0;
      end
      else
      begin
         wait_meta <= {tx_wr_wait, tx_rd_wait};
         wait_sync <= wait_meta;
      end
   end

   assign etx_wr_wait = wait_sync[1];
   assign etx_rd_wait = wait_sync[0];

   // Free when idle or on the last beat
   assign proto_ready = (state == ST_IDLE) || (state == ST_PAYLOAD);
   assign accept      = etx_access && proto_ready;

   // Header byte sits at the top of the upper half
   assign hdr_byte = {etx_txn.ctrlmode, etx_txn.datamode, etx_txn.write, HDR_ACCESS_BIT};
   assign hdr_beat = {hdr_byte, 24'h000000, etx_txn.dstaddr};
   assign pay_beat = {txn_q.data, txn_q.srcaddr};

   always_ff @(posedge tx_lclk_par)
   begin
      if (accept)
      begin
         txn_q <= etx_txn;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         state        <= ST_IDLE;
         tx_frame_par <= '0;
         tx_data_par  <= '0;
      end
      else
      begin
         case (state)
            ST_HEADER:
            begin
               state        <= ST_PAYLOAD;       // Second beat always follows
               tx_frame_par <= FRAME_ON;
               tx_data_par  <= pay_beat;
            end
            default:                             // Idle or payload, may start a packet
            begin
               if (accept)
               begin
                  state        <= ST_HEADER;
                  tx_frame_par <= FRAME_ON;
                  tx_data_par  <= hdr_beat;
               end
               else
               begin
                  state        <= ST_IDLE;
                  tx_frame_par <= '0;            // Frame drops between packets
                  tx_data_par  <= '0;
               end
            end
         endcase
      end
   end

endmodule

// File: etx_top.sv
`timescale 1ns/100ps

module etx_top (
   input  logic                        tx_lclk_par,
   input  logic                        rst,
   input  logic                        emwr_access,     // Write request strobe
   input  etx_pkg::emesh_txn_t         emwr_txn,
   input  logic                        emrq_access,     // Read request strobe
   input  etx_pkg::emesh_txn_t         emrq_txn,
   input  logic                        emrr_access,     // Read response strobe
   input  etx_pkg::emesh_txn_t         emrr_txn,
   input  logic                        tx_rd_wait,
   input  logic                        tx_wr_wait,
   output logic                        emwr_progfull,
   output logic                        emrq_progfull,
   output logic                        emrr_progfull,
   output logic [etx_pkg::FRAME_W-1:0] tx_frame_par,
   output logic [etx_pkg::PAR_DW-1:0]  tx_data_par
);
   import etx_pkg::*;

   logic       wr_valid;                         // Queue heads toward the arbiter
   logic       rq_valid;
   logic       rr_valid;
   emesh_txn_t wr_head;
   emesh_txn_t rq_head;
   emesh_txn_t rr_head;
   logic       wr_pop;                           // Arbiter pops back to queues
   logic       rq_pop;
   logic       rr_pop;
   logic       etx_access;                       // Arbiter to engine
   emesh_txn_t etx_txn;
   logic       proto_ready;                      // Engine back to arbiter
   logic       etx_rd_wait;
   logic       etx_wr_wait;

   etx_channel_fifo wr_fifo (.tx_lclk_par(tx_lclk_par), .rst(rst),
      .wr_strobe(emwr_access), .wr_txn(emwr_txn), .pop(wr_pop),
      .head_valid(wr_valid), .head_txn(wr_head), .progfull(emwr_progfull));

   etx_channel_fifo rq_fifo (.tx_lclk_par(tx_lclk_par), .rst(rst),
      .wr_strobe(emrq_access), .wr_txn(emrq_txn), .pop(rq_pop),
      .head_valid(rq_valid), .head_txn(rq_head), .progfull(emrq_progfull));

   etx_channel_fifo rr_fifo (.tx_lclk_par(tx_lclk_par), .rst(rst),
      .wr_strobe(emrr_access), .wr_txn(emrr_txn), .pop(rr_pop),
      .head_valid(rr_valid), .head_txn(rr_head), .progfull(emrr_progfull));

   etx_arbiter arbiter (.tx_lclk_par(tx_lclk_par), .rst(rst),
      .wr_valid(wr_valid), .wr_head(wr_head), .rq_valid(rq_valid), .rq_head(rq_head),
      .rr_valid(rr_valid), .rr_head(rr_head), .proto_ready(proto_ready),
      .etx_rd_wait(etx_rd_wait), .etx_wr_wait(etx_wr_wait),
      .wr_pop(wr_pop), .rq_pop(rq_pop), .rr_pop(rr_pop),
      .etx_access(etx_access), .etx_txn(etx_txn));

   etx_protocol protocol (.tx_lclk_par(tx_lclk_par), .rst(rst),
      .etx_access(etx_access), .etx_txn(etx_txn),
      .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
      .proto_ready(proto_ready), .etx_rd_wait(etx_rd_wait), .etx_wr_wait(etx_wr_wait),
      .tx_frame_par(tx_frame_par), .tx_data_par(tx_data_par));

endmodule

// File: flist.f
etx_pkg.sv
etx_channel_fifo.sv
etx_arbiter.sv
etx_protocol.sv
etx_top.sv
etx_assertions.sv
tb_etx.sv

// File: tb_etx.sv
`timescale 1ns/100ps

module tb_etx;
   import etx_pkg::*;

   localparam int WAIT_LIMIT  = 400;             // Cycles allowed for any drain
   localparam int RAND_CYCLES = 600;             // Length of the random run

   logic               tx_lclk_par;
   logic               rst;
   logic               emwr_access;
   logic               emrq_access;
   logic               emrr_access;
   emesh_txn_t         emwr_txn;
   emesh_txn_t         emrq_txn;
   emesh_txn_t         emrr_txn;
   logic               tx_rd_wait;
   logic               tx_wr_wait;
   logic               emwr_progfull;
   logic               emrq_progfull;
   logic               emrr_progfull;
   logic [FRAME_W-1:0] tx_frame_par;
   logic [PAR_DW-1:0]  tx_data_par;

   logic [31:0] lfsr = 32'he3ad4b94;             // Stimulus state
   logic        rd_hold;                         // Requested pushback levels
   logic        wr_hold;
   emesh_txn_t  wr_q[$];                         // Model queues per channel
   emesh_txn_t  rq_q[$];
   emesh_txn_t  rr_q[$];
   chan_e       seen[$];                         // Channel order on the link
   emesh_txn_t  pkt;                             // Packet being decoded
   logic        in_pkt;                          // Header beat already taken

   etx_top DUT (.*);

   initial
   begin
      tx_lclk_par = 1'b0;
      forever #5 tx_lclk_par = ~tx_lclk_par;
   end

   task automatic stop_run();
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_txn(input emesh_txn_t got, input emesh_txn_t exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_chan(input chan_e got, input chan_e exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
         stop_run();
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], next_bit()};              // One step per bit taken
      return v;
   endfunction

   // Channel tag lives in ctrlmode[1:0]
   function automatic emesh_txn_t make_txn(input chan_e ch);
      emesh_txn_t  t;
      logic [31:0] r;
      r          = rand_bits(2);
      t.datamode = r[1:0];
      r          = rand_bits(2);
      t.ctrlmode = {r[1:0], ch};
      t.write    = (ch != CH_RQ);                // Read requests are the only non-writes
      t.dstaddr  = rand_bits(32);
      t.data     = rand_bits(32);
      t.srcaddr  = rand_bits(32);
      return t;
   endfunction

   task automatic step(input logic w, input logic q, input logic r);
      emesh_txn_t t;
      @(posedge tx_lclk_par);
      emwr_access <= w;
      emrq_access <= q;
      emrr_access <= r;
      tx_rd_wait  <= rd_hold;
      tx_wr_wait  <= wr_hold;
      if (w)
      begin
         t = make_txn(CH_WR);
         emwr_txn <= t;
         wr_q.push_back(t);
      end
      if (q)
      begin
         t = make_txn(CH_RQ);
         emrq_txn <= t;
         rq_q.push_back(t);
      end
      if (r)
      begin
         t = make_txn(CH_RR);
         emrr_txn <= t;
         rr_q.push_back(t);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, 1'b0, 1'b0);
   endtask

   task automatic load_queues(input int nw, input int nq, input int nr);
      for (int i = 0; i < FIFO_DEPTH; i++)
         step(i < nw, i < nq, i < nr);
   endtask

   task automatic wait_empty(input logic w, input logic q, input logic r, input string what);
      int n;
      n = 0;
      while ((w && wr_q.size() != 0) || (q && rq_q.size() != 0) || (r && rr_q.size() != 0))
      begin
         step(1'b0, 1'b0, 1'b0);
         n++;
         if (n > WAIT_LIMIT)
         begin
            $display("Timeout at %0t: %s entries never left the link", $time, what);
            stop_run();
         end
      end
   endtask

   // Pops the tagged model queue and compares the whole transaction
   task automatic match_packet();
      chan_e      tag;
      emesh_txn_t exp;
      logic       found;
      tag = chan_e'(pkt.ctrlmode[1:0]);
      case (tag)
         CH_WR:   found = (wr_q.size() != 0);
         CH_RQ:   found = (rq_q.size() != 0);
         CH_RR:   found = (rr_q.size() != 0);
         default: found = 1'b0;
      endcase
      if (!found)
      begin
         $display("Packet at %0t with tag %0d matches nothing pending", $time, pkt.ctrlmode[1:0]);
         stop_run();
      end
      case (tag)
         CH_WR:   exp = wr_q.pop_front();
         CH_RQ:   exp = rq_q.pop_front();
         default: exp = rr_q.pop_front();
      endcase
      check_txn(pkt, exp, "decoded packet");
      seen.push_back(tag);
   endtask

   // Link monitor sampled mid-cycle
   always @(negedge tx_lclk_par)
   begin
      if (rst !== 1'b0)
      begin
         in_pkt = 1'b0;
      end
      else if (tx_frame_par != '0)
      begin
         check_flag(tx_frame_par == FRAME_ON, 1'b1, "frame value");
         if (!in_pkt)
         begin
            pkt.ctrlmode = tx_data_par[63:60];   // Header byte from the MSB down
            pkt.datamode = tx_data_par[59:58];
            pkt.write    = tx_data_par[57];
            pkt.dstaddr  = tx_data_par[31:0];
            check_flag(tx_data_par[56], HDR_ACCESS_BIT, "header access flag");
            check_flag(tx_data_par[55:32] == 24'h0, 1'b1, "header pad bits zero");
            in_pkt = 1'b1;
         end
         else
         begin
            pkt.data    = tx_data_par[63:32];
            pkt.srcaddr = tx_data_par[31:0];
            in_pkt      = 1'b0;
            match_packet();
         end
      end
      else
      begin
         check_flag(in_pkt, 1'b0, "frame dropped after header");
      end
   end

   initial
   begin
      int          n_w;
      int          n_q;
      int          n_r;
      logic        w;
      logic        q;
      logic        r;
      logic [31:0] v;
      rst         = 1'b1;
      emwr_access = 1'b0;
      emrq_access = 1'b0;
      emrr_access = 1'b0;
      emwr_txn    = '0;
      emrq_txn    = '0;
      emrr_txn    = '0;
      tx_rd_wait  = 1'b0;
      tx_wr_wait  = 1'b0;
      rd_hold     = 1'b0;
      wr_hold     = 1'b0;
      idle(8);
      rst <= 1'b0;

      // Quiet after reset then one packet per channel
      @(negedge tx_lclk_par);
      check_flag(emwr_progfull, 1'b0, "write progfull after reset");
      check_flag(emrq_progfull, 1'b0, "request progfull after reset");
      check_flag(emrr_progfull, 1'b0, "response progfull after reset");
      check_flag(tx_frame_par == '0, 1'b1, "frame idle after reset");
      check_flag(tx_data_par == '0, 1'b1, "data idle after reset");
      step(1'b1, 1'b0, 1'b0);
      wait_empty(1'b1, 1'b1, 1'b1, "single write");
      step(1'b0, 1'b1, 1'b0);
      wait_empty(1'b1, 1'b1, 1'b1, "single read request");
      step(1'b0, 1'b0, 1'b1);
      wait_empty(1'b1, 1'b1, 1'b1, "single read response");

      // Fill levels against progfull
      rd_hold = 1'b1;
      wr_hold = 1'b1;
      idle(4);                                   // Sync delay plus margin
      n_w = rand_bits(4) % (FIFO_DEPTH + 1);
      n_q = rand_bits(4) % (FIFO_DEPTH + 1);
      n_r = rand_bits(4) % (FIFO_DEPTH + 1);
      load_queues(n_w, n_q, n_r);
      idle(2);
      @(negedge tx_lclk_par);
      check_flag(emwr_progfull, n_w >= PROGFULL_LEVEL, "write progfull level");
      check_flag(emrq_progfull, n_q >= PROGFULL_LEVEL, "request progfull level");
      check_flag(emrr_progfull, n_r >= PROGFULL_LEVEL, "response progfull level");
      rd_hold = 1'b0;
      wr_hold = 1'b0;
      wait_empty(1'b1, 1'b1, 1'b1, "progfull run");

      // Fixed priority after a joint release
      rd_hold = 1'b1;
      wr_hold = 1'b1;
      idle(4);
      n_w = 1 + rand_bits(3);
      n_q = 1 + rand_bits(3);
      n_r = 1 + rand_bits(3);
      load_queues(n_w, n_q, n_r);
      seen.delete();
      rd_hold = 1'b0;
      wr_hold = 1'b0;
      wait_empty(1'b1, 1'b1, 1'b1, "priority run");
      foreach (seen[i])
         check_chan(seen[i], (i < n_r) ? CH_RR : (i < n_r + n_q) ? CH_RQ : CH_WR,
            "arbitration order");

      // Write wait blocks writes and responses while read wait blocks requests
      rd_hold = 1'b1;
      wr_hold = 1'b1;
      idle(4);
      n_w = 1 + rand_bits(3);
      n_q = 1 + rand_bits(3);
      n_r = 1 + rand_bits(3);
      load_queues(n_w, n_q, n_r);
      seen.delete();
      rd_hold = 1'b0;
      wait_empty(1'b0, 1'b1, 1'b0, "read request under write wait");
      idle(6);
      foreach (seen[i])
         check_chan(seen[i], CH_RQ, "channel under write wait");
      check_flag(DUT.wr_valid && DUT.rr_valid, 1'b1, "blocked queues kept");
      rd_hold = 1'b1;
      idle(4);
      n_q = 1 + rand_bits(3);
      load_queues(0, n_q, 0);
      seen.delete();
      wr_hold = 1'b0;
      wait_empty(1'b1, 1'b0, 1'b1, "write path under read wait");
      idle(6);
      foreach (seen[i])
         check_flag(seen[i] != CH_RQ, 1'b1, "no read request under read wait");
      rd_hold = 1'b0;
      wait_empty(1'b1, 1'b1, 1'b1, "pushback release");

      // Random strobes and wait toggles
      for (int i = 0; i < RAND_CYCLES; i++)
      begin
         @(negedge tx_lclk_par);
         v = rand_bits(3);
         w = v[0] && !emwr_progfull;             // Writer pauses on progfull
         q = v[1] && !emrq_progfull;
         r = v[2] && !emrr_progfull;
         v = rand_bits(4);
         if (v[3:0] == 4'h0)
            rd_hold = !rd_hold;
         v = rand_bits(4);
         if (v[3:0] == 4'h0)
            wr_hold = !wr_hold;
         step(w, q, r);
      end
      rd_hold = 1'b0;
      wr_hold = 1'b0;
      wait_empty(1'b1, 1'b1, 1'b1, "random run");
      idle(8);
      @(negedge tx_lclk_par);
      check_flag(DUT.wr_valid | DUT.rq_valid | DUT.rr_valid, 1'b0, "queues empty after drain");
      check_flag(emwr_progfull | emrq_progfull | emrr_progfull, 1'b0, "progfull after drain");
      $display("Test OK");
      $finish;
   end

endmodule
